// File: source/vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// SVGA 800x600 at 60 Hz, 40 MHz pixel clock, syncs active high.
`define H_ACTIVE    800
`define H_FRONT     40
`define H_SYNC      128
`define H_TOTAL     1056

`define V_ACTIVE    600
`define V_FRONT     1
`define V_SYNC      4
`define V_TOTAL     628

// Text rows: 16 glyphs of 8x16 cells, each pixel scaled by 2**SCALE_POW.
`define TEXT_COLS   16
`define TEXT_STAGES 4
`define TEXT_X      64
`define TEXT_Y0     100
`define TEXT_PITCH  80
`define SCALE_POW   2
`define CELL_HEIGHT 16

`define TEXT_COLOUR 12'hF00
`define BG_COLOUR   12'h00F

`endif

// File: source/vga_pkg.sv
package vga_pkg;

    // Pixel and line counters.
    typedef logic [10:0] coord_t;

    // 4 bits per channel, red in the top nibble.
    typedef logic [11:0] rgb_t;

    // Index into the 8-glyph font.
    typedef logic [2:0] glyph_t;

    // One font row. Bit 7 is the leftmost pixel.
    typedef logic [7:0] glyph_row_t;

    // Glyph position within a text row.
    typedef logic [3:0] col_t;

    // Line within a 16-line cell.
    typedef logic [3:0] line_t;

    // Selects one overlay stage for host writes.
    typedef logic [1:0] stage_t;

endpackage

// File: source/vga_timing.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module vga_timing import vga_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   hblnk,
    output logic   vblnk,
    output rgb_t   rgb
);

    localparam coord_t H_ACT    = coord_t'(`H_ACTIVE);
    localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
    localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
    localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam coord_t V_ACT    = coord_t'(`V_ACTIVE);
    localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
    localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
    localparam coord_t VS_END   = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    coord_t hcnt;
    coord_t vcnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_LAST) begin
            hcnt <= '0;
            if (vcnt == V_LAST) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // All outputs are decoded from the same count, so they leave aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b1;
            vblnk  <= 1'b1;
            rgb    <= '0;
        end else begin
            hcount <= hcnt;
            vcount <= vcnt;
            hsync  <= (hcnt >= HS_START) && (hcnt < HS_END);
            vsync  <= (vcnt >= VS_START) && (vcnt < VS_END);
            hblnk  <= hcnt >= H_ACT;
            vblnk  <= vcnt >= V_ACT;
            rgb    <= ((hcnt < H_ACT) && (vcnt < V_ACT)) ? rgb_t'(`BG_COLOUR) : '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        hcount < coord_t'(`H_TOTAL))
        else $error("vga_timing: hcount reached H_TOTAL");

endmodule

// File: source/text_buffer.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module text_buffer import vga_pkg::*; #(
    parameter int STAGE_INDEX = 0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wr_en,
    input  stage_t wr_stage,
    input  col_t   wr_col,
    input  glyph_t wr_glyph,
    input  col_t   rd_col,
    output glyph_t glyph
);

    glyph_t mem [`TEXT_COLS];

    // Every stage sees the same write port and keeps only its own writes.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TEXT_COLS; i++) begin
                mem[i] <= '0;
            end
            glyph <= '0;
        end else begin
            if (wr_en && (wr_stage == stage_t'(STAGE_INDEX))) begin
                mem[wr_col] <= wr_glyph;
            end
            glyph <= mem[rd_col];
        end
    end

endmodule

// File: source/font_rom.sv
`timescale 1ns/1ns

module font_rom import vga_pkg::*; (
    input  logic       clk,
    input  glyph_t     glyph,
    input  logic [2:0] row,
    output glyph_row_t pixels
);

    // Eight rows per glyph, glyph code in the upper address bits.
    glyph_row_t rom [64];

    initial begin
        $readmemh("font.mem", rom);
    end

    always_ff @(posedge clk) begin
        pixels <= rom[{glyph, row}];
    end

endmodule

// File: source/text_overlay.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module text_overlay import vga_pkg::*; #(
    parameter int STAGE_INDEX = 0,
    parameter int CHAR_YPOS   = `TEXT_Y0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   enable,
    input  logic   wr_en,
    input  stage_t wr_stage,
    input  col_t   wr_col,
    input  glyph_t wr_glyph,
    input  coord_t in_hcount,
    input  coord_t in_vcount,
    input  logic   in_hsync,
    input  logic   in_vsync,
    input  logic   in_hblnk,
    input  logic   in_vblnk,
    input  rgb_t   in_rgb,
    output coord_t out_hcount,
    output coord_t out_vcount,
    output logic   out_hsync,
    output logic   out_vsync,
    output logic   out_hblnk,
    output logic   out_vblnk,
    output rgb_t   out_rgb
);

    localparam coord_t X_MIN = coord_t'(`TEXT_X);
    localparam coord_t X_MAX = coord_t'(`TEXT_X + ((`TEXT_COLS << 3) << `SCALE_POW));
    localparam coord_t Y_MIN = coord_t'(CHAR_YPOS);
    localparam coord_t Y_MAX = coord_t'(CHAR_YPOS + (`CELL_HEIGHT << `SCALE_POW));

    coord_t hcount_i, hcount_ii, hcount_iii;
    coord_t vcount_i, vcount_ii, vcount_iii;
    logic   hsync_i, hsync_ii, hsync_iii;
    logic   vsync_i, vsync_ii, vsync_iii;
    logic   hblnk_i, hblnk_ii, hblnk_iii;
    logic   vblnk_i, vblnk_ii, vblnk_iii;
    rgb_t   rgb_i, rgb_ii, rgb_iii, rgb_nxt;

    col_t       char_xy, char_xy_nxt;
    line_t      char_line, char_line_nxt;
    glyph_t     glyph;
    glyph_row_t char_line_pixels;
    coord_t     pixel_index;
    logic [2:0] bit_index;

    // Each glyph is 32 pixels wide and each font line 4 lines high, so shifts suffice.
    assign char_xy_nxt = (in_hcount >= X_MIN) ?
                         col_t'(((in_hcount - X_MIN) >> 3) >> `SCALE_POW) : '0;
    assign char_line_nxt = (vcount_i >= Y_MIN) ?
                           line_t'((vcount_i - Y_MIN) >> `SCALE_POW) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            char_xy   <= '0;
            char_line <= '0;
        end else begin
            char_xy   <= char_xy_nxt;
            char_line <= char_line_nxt;
        end
    end

    text_buffer #(
        .STAGE_INDEX(STAGE_INDEX)
    ) i_text_buffer (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_stage (wr_stage),
        .wr_col   (wr_col),
        .wr_glyph (wr_glyph),
        .rd_col   (char_xy),
        .glyph    (glyph)
    );

    // Each font row covers two cell lines.
    font_rom i_font_rom (
        .clk    (clk),
        .glyph  (glyph),
        .row    (char_line[3:1]),
        .pixels (char_line_pixels)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            {hcount_i, vcount_i, hsync_i, vsync_i, hblnk_i, vblnk_i} <= {22'd0, 4'b0011};
            {hcount_ii, vcount_ii, hsync_ii, vsync_ii, hblnk_ii, vblnk_ii} <= {22'd0, 4'b0011};
            {hcount_iii, vcount_iii, hsync_iii, vsync_iii, hblnk_iii, vblnk_iii} <=
                {22'd0, 4'b0011};
            {out_hcount, out_vcount, out_hsync, out_vsync, out_hblnk, out_vblnk} <=
                {22'd0, 4'b0011};
        end else begin
            {hcount_i, vcount_i, hsync_i, vsync_i, hblnk_i, vblnk_i} <=
                {in_hcount, in_vcount, in_hsync, in_vsync, in_hblnk, in_vblnk};
            {hcount_ii, vcount_ii, hsync_ii, vsync_ii, hblnk_ii, vblnk_ii} <=
                {hcount_i, vcount_i, hsync_i, vsync_i, hblnk_i, vblnk_i};
            {hcount_iii, vcount_iii, hsync_iii, vsync_iii, hblnk_iii, vblnk_iii} <=
                {hcount_ii, vcount_ii, hsync_ii, vsync_ii, hblnk_ii, vblnk_ii};
            {out_hcount, out_vcount, out_hsync, out_vsync, out_hblnk, out_vblnk} <=
                {hcount_iii, vcount_iii, hsync_iii, vsync_iii, hblnk_iii, vblnk_iii};
        end
    end

    always_ff @(posedge clk) begin
        rgb_i   <= in_rgb;
        rgb_ii  <= rgb_i;
        rgb_iii <= rgb_ii;
        out_rgb <= rgb_nxt;
    end

    // The font row for this pixel arrives together with stage III.
    always_comb begin
        pixel_index = (hcount_iii - X_MIN) >> `SCALE_POW;
        bit_index   = 3'd7 - pixel_index[2:0];
        rgb_nxt     = rgb_iii;
        if (enable && (hcount_iii >= X_MIN) && (hcount_iii < X_MAX) &&
            (vcount_iii >= Y_MIN) && (vcount_iii < Y_MAX)) begin
            if (char_line_pixels[bit_index]) begin
                rgb_nxt = rgb_t'(`TEXT_COLOUR);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 4) |-> out_hsync == $past(in_hsync, 4))
        else $error("text_overlay %0d: hsync not delayed by four cycles", STAGE_INDEX);

endmodule

// File: source/vga_out.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module vga_out import vga_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coord_t hcount,
    input  coord_t vcount,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   hblnk,
    input  logic   vblnk,
    input  rgb_t   rgb_in,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output rgb_t   rgb
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            rgb   <= '0;
        end else begin
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= ~(hblnk | vblnk);
            rgb   <= (hblnk | vblnk) ? '0 : rgb_in;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !de |-> rgb == '0)
        else $error("vga_out: colour not black while de is low");

    // Blanking decoded in vga_timing must still match the counts after the overlay chain.
    assert property (@(posedge clk) disable iff (rst)
        (hcount >= coord_t'(`H_ACTIVE)) || (vcount >= coord_t'(`V_ACTIVE)) |=> !de)
        else $error("vga_out: de high outside the active area");

endmodule

// File: source/vga_text_top.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module vga_text_top import vga_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`TEXT_STAGES-1:0]   enable,
    input  logic                      wr_en,
    input  stage_t                    wr_stage,
    input  col_t                      wr_col,
    input  glyph_t                    wr_glyph,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output rgb_t                      rgb
);

    // Entry i feeds overlay stage i; the last entry feeds the output stage.
    coord_t s_hcount [`TEXT_STAGES+1];
    coord_t s_vcount [`TEXT_STAGES+1];
    logic   s_hsync  [`TEXT_STAGES+1];
    logic   s_vsync  [`TEXT_STAGES+1];
    logic   s_hblnk  [`TEXT_STAGES+1];
    logic   s_vblnk  [`TEXT_STAGES+1];
    rgb_t   s_rgb    [`TEXT_STAGES+1];

    vga_timing i_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (s_hcount[0]),
        .vcount (s_vcount[0]),
        .hsync  (s_hsync[0]),
        .vsync  (s_vsync[0]),
        .hblnk  (s_hblnk[0]),
        .vblnk  (s_vblnk[0]),
        .rgb    (s_rgb[0])
    );

    for (genvar i = 0; i < `TEXT_STAGES; i++) begin : g_stage
        text_overlay #(
            .STAGE_INDEX (i),
            .CHAR_YPOS   (`TEXT_Y0 + i * `TEXT_PITCH)
        ) i_text_overlay (
            .clk        (clk),
            .rst        (rst),
            .enable     (enable[i]),
            .wr_en      (wr_en),
            .wr_stage   (wr_stage),
            .wr_col     (wr_col),
            .wr_glyph   (wr_glyph),
            .in_hcount  (s_hcount[i]),
            .in_vcount  (s_vcount[i]),
            .in_hsync   (s_hsync[i]),
            .in_vsync   (s_vsync[i]),
            .in_hblnk   (s_hblnk[i]),
            .in_vblnk   (s_vblnk[i]),
            .in_rgb     (s_rgb[i]),
            .out_hcount (s_hcount[i+1]),
            .out_vcount (s_vcount[i+1]),
            .out_hsync  (s_hsync[i+1]),
            .out_vsync  (s_vsync[i+1]),
            .out_hblnk  (s_hblnk[i+1]),
            .out_vblnk  (s_vblnk[i+1]),
            .out_rgb    (s_rgb[i+1])
        );
    end

    vga_out i_vga_out (
        .clk      (clk),
        .rst      (rst),
        .hcount   (s_hcount[`TEXT_STAGES]),
        .vcount   (s_vcount[`TEXT_STAGES]),
        .hsync_in (s_hsync[`TEXT_STAGES]),
        .vsync_in (s_vsync[`TEXT_STAGES]),
        .hblnk    (s_hblnk[`TEXT_STAGES]),
        .vblnk    (s_vblnk[`TEXT_STAGES]),
        .rgb_in   (s_rgb[`TEXT_STAGES]),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

endmodule

// File: dv/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic note_error();
    error_count++;
    if (error_count == MAX_PRINTED) begin
        $display("Too many mismatches, further ERROR lines are not printed");
    end
endtask

task automatic check_rgb(string name, rgb_t expected, rgb_t actual);
    if (actual !== expected) begin
        if (error_count < MAX_PRINTED) begin
            $display("ERROR %s at x=%0d y=%0d: expected %h, actual %h",
                     name, pix_x, pix_y, expected, actual);
        end
        note_error();
    end
endtask

task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
        if (error_count < MAX_PRINTED) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
        note_error();
    end
endtask

task automatic check_count(string name, coord_t expected, coord_t actual);
    if (actual !== expected) begin
        if (error_count < MAX_PRINTED) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
        note_error();
    end
endtask

// Each cell is 32x64 pixels from TEXT_X on, and each font bit covers 4 pixels by 8 lines.
function automatic rgb_t expected_pixel(int x, int y);
    int     top;
    int     col;
    int     pix_bit;
    int     font_row;
    glyph_t code;
    rgb_t   result;
    result = `BG_COLOUR;
    for (int s = 0; s < `TEXT_STAGES; s++) begin
        top = `TEXT_Y0 + s * `TEXT_PITCH;
        if (enable[s] && x >= `TEXT_X && x < `TEXT_X + `TEXT_COLS * 32 &&
            y >= top && y < top + 64) begin
            col      = (x - `TEXT_X) / 32;
            pix_bit  = ((x - `TEXT_X) / 4) % 8;
            font_row = ((y - top) / 4) / 2;
            code     = model_glyph[s][col];
            if (font_model[int'(code) * 8 + font_row][7 - pix_bit]) begin
                result = `TEXT_COLOUR;
            end
        end
    end
    return result;
endfunction

task automatic count_text(int y);
    int top;
    for (int s = 0; s < `TEXT_STAGES; s++) begin
        top = `TEXT_Y0 + s * `TEXT_PITCH;
        if (y >= top && y < top + 64 && rgb == `TEXT_COLOUR) begin
            painted[s]++;
        end
    end
endtask

// Checks every pixel up to the next rising vsync against the model.
// Started in vertical blanking, this covers the whole following frame.
task automatic check_frame();
    @(posedge clk);
    for (int s = 0; s < `TEXT_STAGES; s++) begin
        painted[s] = 0;
    end
    frame_check = 1'b1;
    @(posedge vsync);
    frame_check = 1'b0;
endtask

task automatic write_glyph(stage_t stage, col_t col, glyph_t code);
    @(posedge clk);
    #1;
    wr_en    = 1'b1;
    wr_stage = stage;
    wr_col   = col;
    wr_glyph = code;
    model_glyph[stage][col] = code;
    @(posedge clk);
    #1 wr_en = 1'b0;
endtask

task automatic test_reset_outputs();
    test_name = "reset_outputs";
    // The first count needs one cycle in the timing generator, four per overlay stage
    // and one in the output register before it reaches the ports.
    repeat (1 + 4 * `TEXT_STAGES + 1) begin
        @(negedge clk);
        check_bit("reset_outputs hsync", 1'b0, hsync);
        check_bit("reset_outputs vsync", 1'b0, vsync);
        check_bit("reset_outputs de", 1'b0, de);
        check_rgb("reset_outputs rgb", '0, rgb);
    end
    @(negedge clk);
    check_bit("reset_outputs first de", 1'b1, de);
    check_rgb("reset_outputs first pixel", rgb_t'(`BG_COLOUR), rgb);
endtask

task automatic test_sync_timing();
    int   period;
    int   width;
    int   run;
    int   lines;
    logic last;
    logic last_en;
    logic rise;
    test_name = "sync_timing";
    period    = 0;
    width     = 0;
    @(posedge hsync);
    last = 1'b1;
    rise = 1'b0;
    while (!rise) begin
        @(negedge clk);
        rise = hsync && !last;
        if (!rise) begin
            period++;
            if (hsync) begin
                width++;
            end
        end
        last = hsync;
    end
    check_count("sync_timing hsync period", coord_t'(`H_TOTAL), coord_t'(period));
    check_count("sync_timing hsync width", coord_t'(`H_SYNC), coord_t'(width));
    run     = 0;
    lines   = 0;
    @(posedge vsync);
    last    = 1'b1;
    last_en = 1'b0;
    rise    = 1'b0;
    while (!rise) begin
        @(negedge clk);
        rise = vsync && !last;
        if (de) begin
            run++;
        end else if (last_en) begin
            check_count("sync_timing de length", coord_t'(`H_ACTIVE), coord_t'(run));
            lines++;
            run = 0;
        end
        last_en = de;
        last    = vsync;
    end
    check_count("sync_timing active lines", coord_t'(`V_ACTIVE), coord_t'(lines));
endtask

task automatic test_background();
    test_name = "background";
    check_frame();
endtask

task automatic test_random_text();
    test_name = "random_text";
    for (int c = 0; c < `TEXT_COLS; c++) begin
        write_glyph(stage_t'(0), col_t'(c), glyph_t'($urandom_range(7, 1)));
        write_glyph(stage_t'(2), col_t'(c), glyph_t'($urandom_range(7, 1)));
    end
    check_frame();
endtask

task automatic test_stage_disable();
    test_name = "stage_disable";
    @(posedge clk);
    #1 enable = 4'b1110;
    check_frame();
    check_bit("stage_disable stage 0 painted", 1'b0, painted[0] != 0);
    check_bit("stage_disable stage 2 painted", 1'b1, painted[2] != 0);
    @(posedge clk);
    #1 enable = '1;
endtask

task automatic test_cell_rewrite();
    int expected;
    test_name = "cell_rewrite";
    write_glyph(stage_t'(3), col_t'(9), glyph_t'(6));
    check_frame();
    expected = 0;
    for (int r = 0; r < 8; r++) begin
        expected += $countones(font_model[6 * 8 + r]) * 4 * 8;
    end
    check_count("cell_rewrite stage 3 pixels", coord_t'(expected), coord_t'(painted[3]));
endtask

`endif

// File: dv/tb_vga_text.sv
`timescale 1ns/1ns
`include "vga_params.svh"

module tb_vga_text import vga_pkg::*; ();

    localparam int TEST_COUNT     = 6;
    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * 3 * FRAME_CYCLES;
    localparam int MAX_PRINTED    = 50;

    logic                    clk;
    logic                    rst;
    logic [`TEXT_STAGES-1:0] enable;
    logic                    wr_en;
    stage_t                  wr_stage;
    col_t                    wr_col;
    glyph_t                  wr_glyph;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    rgb_t                    rgb;

    // Reference state for the pixel rule.
    glyph_row_t font_model [64];
    glyph_t     model_glyph [`TEXT_STAGES][`TEXT_COLS];

    string       test_name;
    int          error_count = 0;
    int unsigned cycle_count = 0;
    logic        frame_check;
    int          painted [`TEXT_STAGES];
    int          pix_x;
    int          pix_y;
    logic        last_de;
    logic        last_vsync;

    `include "tb_tasks.svh"

    vga_text_top i_vga_text_top (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .wr_en    (wr_en),
        .wr_stage (wr_stage),
        .wr_col   (wr_col),
        .wr_glyph (wr_glyph),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("Errors: %0d", error_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Position is rebuilt from the ports alone, sampled away from the active edge.
    always @(negedge clk) begin
        if (rst) begin
            pix_x      = 0;
            pix_y      = 0;
            last_de    = 1'b0;
            last_vsync = 1'b0;
        end else begin
            if (vsync && !last_vsync) begin
                pix_y = 0;
            end
            if (de) begin
                if (frame_check) begin
                    check_rgb(test_name, expected_pixel(pix_x, pix_y), rgb);
                    count_text(pix_y);
                end
                pix_x++;
            end else begin
                if (frame_check) begin
                    check_rgb({test_name, " blanking"}, '0, rgb);
                end
                if (last_de) begin
                    pix_x = 0;
                    pix_y++;
                end
            end
            last_de    = de;
            last_vsync = vsync;
        end
    end

    initial begin
        void'($urandom(32'h50446efb));
        rst         = 1'b1;
        enable      = '1;
        wr_en       = 1'b0;
        wr_stage    = '0;
        wr_col      = '0;
        wr_glyph    = '0;
        frame_check = 1'b0;
        test_name   = "reset";
        $readmemh("source/font.mem", font_model);
        for (int s = 0; s < `TEXT_STAGES; s++) begin
            for (int c = 0; c < `TEXT_COLS; c++) begin
                model_glyph[s][c] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        test_reset_outputs();
        test_sync_timing();
        test_background();
        test_random_text();
        test_stage_disable();
        test_cell_rewrite();

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: source/font.mem
// One glyph row per line as two hex digits, bit 7 is the leftmost pixel.
// Eight rows per glyph, glyph 0 first. Glyph 0 stays blank.
00
00
00
00
00
00
00
00
18
24
42
7E
42
42
42
00
7C
42
42
7C
42
42
7C
00
3C
42
40
40
40
42
3C
00
78
44
42
42
42
44
78
00
7E
40
40
7C
40
40
7E
00
AA
55
AA
55
AA
55
AA
55
FF
FF
FF
FF
FF
FF
FF
FF

// File: all.f
+incdir+source
+incdir+dv
source/vga_pkg.sv
source/vga_timing.sv
source/text_buffer.sv
source/font_rom.sv
source/text_overlay.sv
source/vga_out.sv
source/vga_text_top.sv
dv/tb_vga_text.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_vga_text \
    -f all.f -o sim_vga_text
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# The font ROM loads font.mem from the working directory.
cp source/font.mem font.mem
if [ $? -ne 0 ]; then
    echo "Could not copy font.mem"
    exit 1
fi

./obj_dir/sim_vga_text > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
exit 1
